/* tb.f */
+incdir+verilog
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/insn_decoder.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/hazard_unit.sv
verilog/rv_core.sv
tests/core_tb.sv

/* run.sh */
#!/bin/sh
# build the core testbench with Verilator, run it, and look for the passing line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f \
  --top-module core_tb -o core_tb_sim \
  && ./obj_dir/core_tb_sim | tee /dev/stderr | grep -x 'test passed' > /dev/null \
  && echo "simulation ok" \
  || { echo "simulation reported a failure"; exit 1; }

/* tests/core_tb.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module core_tb
  import isa_pkg::*;
();

  typedef logic [`DMEM_AW-1:0] dword_addr_t;

  localparam word_t       RESET_PC_W     = `RESET_PC;
  localparam logic [`IMEM_AW-1:0] RESET_FETCH = RESET_PC_W[`IMEM_AW+1:2];
  localparam int unsigned FINISH_TIMEOUT = 4000;

  logic                CLK = 1'b0;
  logic                RST = 1'b1;
  logic [`IMEM_AW-1:0] imem_addr_o;
  insn_t               imem_rdata;
  logic                dmem_en_o;
  logic                dmem_we_o;
  dword_addr_t         dmem_addr_o;
  word_t               dmem_wdata_o;
  word_t               dmem_rdata = '0;

  insn_t       imem [0:(1<<`IMEM_AW)-1];
  word_t       dram [dword_addr_t];
  word_t       dexp [0:(1<<`DMEM_AW)-1];
  logic        forbidden [0:(1<<`DMEM_AW)-1];
  word_t       shadow [0:31];
  dword_addr_t exp_addr [$];
  word_t       exp_data [$];
  logic [31:0] lfsr_q = 32'ha26e_8c03;
  int unsigned pc_idx;
  int unsigned next_slot;
  int unsigned cyc = 0;
  int          check_errors = 0;
  int          other_errors = 0;

  rv_core uut (
    .CLK          (CLK),
    .RST          (RST),
    .imem_addr_o  (imem_addr_o),
    .imem_rdata_i (imem_rdata),
    .dmem_en_o    (dmem_en_o),
    .dmem_we_o    (dmem_we_o),
    .dmem_addr_o  (dmem_addr_o),
    .dmem_wdata_o (dmem_wdata_o),
    .dmem_rdata_i (dmem_rdata)
  );

  always #5 CLK = ~CLK;

  always @(posedge CLK) begin
    cyc <= cyc + 1;
  end

  ////////////////////////////////////////
  // memory models
  ////////////////////////////////////////

  // unwritten words read a pattern built from the full word address
  function automatic word_t fill_word(dword_addr_t a);
    return {~a, 6'h2a, a, 6'h15};
  endfunction

  assign imem_rdata = imem[imem_addr_o];

  always @(posedge CLK) begin
    if (dmem_en_o) begin
      dmem_rdata <= dram.exists(dmem_addr_o) ? dram[dmem_addr_o]
                                             : fill_word(dmem_addr_o);
      if (dmem_we_o) begin
        dram[dmem_addr_o] = dmem_wdata_o;
      end
    end
  end

  ////////////////////////////////////////
  // random numbers and RV32I rules
  ////////////////////////////////////////

  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = b ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    return b;
  endfunction

  function automatic word_t random_bits(int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // alt is instruction bit 30, SUB and SRA
  function automatic word_t alu_rule(logic [2:0] f3, logic alt, word_t a, word_t b);
    word_t r;
    case (f3)
      3'b000:  r = alt ? a - b : a + b;
      3'b001:  r = a << b[4:0];
      3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  r = (a < b) ? 32'd1 : 32'd0;
      3'b100:  r = a ^ b;
      3'b101:  r = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  ////////////////////////////////////////
  // instruction encoding
  ////////////////////////////////////////

  function automatic insn_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic insn_t i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                   reg_addr_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic insn_t s_type(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic insn_t b_type(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic insn_t j_type(logic [20:0] off, reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  ////////////////////////////////////////
  // program builder with expected state
  ////////////////////////////////////////

  task automatic emit(insn_t w);
    imem[pc_idx] = w;
    pc_idx++;
  endtask

  task automatic set_reg(reg_addr_t rd, word_t v);
    if (rd != 5'd0) begin
      shadow[rd] = v;
    end
  endtask

  task automatic rr_op(logic [2:0] f3, logic alt, reg_addr_t rd, reg_addr_t rs1,
                       reg_addr_t rs2);
    emit(r_type({1'b0, alt, 5'b0}, rs2, rs1, f3, rd));
    set_reg(rd, alu_rule(f3, alt, shadow[rs1], shadow[rs2]));
  endtask

  task automatic imm_op(logic [2:0] f3, logic alt, reg_addr_t rd, reg_addr_t rs1,
                        logic [11:0] imm);
    logic [11:0] field;
    word_t       operand;
    if (f3 == 3'b001 || f3 == 3'b101) begin
      field   = {1'b0, alt, 5'b0, imm[4:0]};
      operand = word_t'(imm[4:0]);
    end else begin
      field   = imm;
      operand = {{20{imm[11]}}, imm};
    end
    emit(i_type(field, rs1, f3, rd, OPC_OP_IMM));
    set_reg(rd, alu_rule(f3, alt && f3 == 3'b101, shadow[rs1], operand));
  endtask

  // lui plus addi, always two words
  task automatic load_const(reg_addr_t rd, word_t v);
    logic [19:0] upper;
    upper = v[31:12] + {19'b0, v[11]};
    emit({upper, rd, OPC_LUI});
    set_reg(rd, {upper, 12'b0});
    imm_op(3'b000, 1'b0, rd, rd, v[11:0]);
  endtask

  task automatic store_slot(reg_addr_t rs2);
    emit(s_type(12'(next_slot << 2), rs2, 5'd0));
    exp_addr.push_back(dword_addr_t'(next_slot));
    exp_data.push_back(shadow[rs2]);
    dexp[next_slot] = shadow[rs2];
    next_slot++;
  endtask

  // a store in the shadow of a taken branch or jump
  task automatic skipped_store(reg_addr_t rs2);
    emit(s_type(12'(next_slot << 2), rs2, 5'd0));
    forbidden[next_slot] = 1'b1;
    next_slot++;
  endtask

  task automatic load_slot(reg_addr_t rd, int unsigned slot);
    emit(i_type(12'(slot << 2), 5'd0, 3'b010, rd, OPC_LOAD));
    set_reg(rd, dexp[slot]);
  endtask

  task automatic branch_over(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2);
    logic taken;
    case (f3)
      3'b000:  taken = shadow[rs1] == shadow[rs2];
      3'b001:  taken = shadow[rs1] != shadow[rs2];
      3'b100:  taken = $signed(shadow[rs1]) < $signed(shadow[rs2]);
      default: taken = $signed(shadow[rs1]) >= $signed(shadow[rs2]);
    endcase
    emit(b_type(13'd8, rs2, rs1, f3));
    if (taken) begin
      skipped_store(rs1);
    end else begin
      store_slot(rs1);
    end
  endtask

  task automatic alu_pair(logic [2:0] f3, logic alt);
    load_const(5'd1, random_bits(32));
    load_const(5'd2, random_bits(32));
    rr_op(f3, alt, 5'd3, 5'd1, 5'd2);
    store_slot(5'd3);
    // no immediate form of SUB
    if (!(f3 == 3'b000 && alt)) begin
      imm_op(f3, alt, 5'd4, 5'd1, 12'(random_bits(12)));
      store_slot(5'd4);
    end
  endtask

  task automatic build_program();
    int unsigned fresh;
    word_t       target;
    for (int f = 0; f < 8; f++) begin
      for (int alt = 0; alt < 2; alt++) begin
        if (alt == 0 || f == 0 || f == 5) begin
          alu_pair(3'(f), alt[0]);
        end
      end
    end
    // dependency chains at distance one, two and three
    load_const(5'd5, random_bits(32));
    imm_op(3'b000, 1'b0, 5'd6, 5'd5, 12'(random_bits(12)));
    rr_op(3'b000, 1'b1, 5'd7, 5'd6, 5'd5);
    imm_op(3'b000, 1'b0, 5'd9, 5'd0, 12'd3);
    rr_op(3'b100, 1'b0, 5'd8, 5'd7, 5'd6);
    store_slot(5'd8);
    store_slot(5'd7);
    store_slot(5'd6);
    // load-use
    load_const(5'd11, random_bits(32));
    store_slot(5'd11);
    load_slot(5'd12, next_slot - 1);
    imm_op(3'b000, 1'b0, 5'd13, 5'd12, 12'(random_bits(12)));
    store_slot(5'd13);
    fresh = next_slot;
    next_slot++;
    load_slot(5'd14, fresh);
    rr_op(3'b100, 1'b0, 5'd15, 5'd14, 5'd11);
    store_slot(5'd15);
    load_slot(5'd22, fresh - 2);
    store_slot(5'd22);
    // branches, each direction for each kept condition
    load_const(5'd16, random_bits(32) & 32'h7fff_ffff);
    load_const(5'd17, shadow[16]);
    load_const(5'd18, random_bits(32) | 32'h8000_0000);
    branch_over(3'b000, 5'd16, 5'd17);
    branch_over(3'b001, 5'd16, 5'd17);
    branch_over(3'b100, 5'd18, 5'd16);
    branch_over(3'b101, 5'd18, 5'd16);
    branch_over(3'b100, 5'd16, 5'd18);
    branch_over(3'b101, 5'd16, 5'd18);
    branch_over(3'b000, 5'd16, 5'd18);
    branch_over(3'b001, 5'd16, 5'd18);
    // jal over one store, link checked by the next one
    set_reg(5'd19, word_t'((pc_idx + 1) * 4));
    emit(j_type(21'd8, 5'd19));
    skipped_store(5'd0);
    store_slot(5'd19);
    // jalr to an odd computed address, bit 0 must be dropped
    target = word_t'((pc_idx + 5) * 4);
    load_const(5'd20, target | 32'd1);
    set_reg(5'd21, word_t'((pc_idx + 1) * 4));
    emit(i_type(12'd0, 5'd20, 3'b000, 5'd21, OPC_JALR));
    skipped_store(5'd20);
    skipped_store(5'd21);
    store_slot(5'd21);
    // x0 stays zero
    imm_op(3'b000, 1'b0, 5'd0, 5'd0, 12'h07b);
    rr_op(3'b000, 1'b0, 5'd0, 5'd1, 5'd2);
    store_slot(5'd0);
    emit(j_type(21'd0, 5'd0));
  endtask

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  always @(posedge CLK) begin
    dword_addr_t want_addr;
    word_t       want_data;
    if (!RST && dmem_we_o) begin
      if (exp_addr.size() == 0) begin
        $display("unexpected extra store to word %0d at %0t", dmem_addr_o, $time);
        other_errors++;
      end else begin
        want_addr = exp_addr.pop_front();
        want_data = exp_data.pop_front();
        assert (dmem_addr_o == want_addr && dmem_wdata_o == want_data)
          else begin
            $display("CHECK FAILED at %0t: store of %h to word %0d, expected %h to word %0d",
                     $time, dmem_wdata_o, dmem_addr_o, want_data, want_addr);
            check_errors++;
          end
      end
    end
  end

  assert property (@(posedge CLK) disable iff (RST) dmem_we_o |-> !forbidden[dmem_addr_o])
    else begin
      $display("CHECK FAILED at %0t: store to word %0d in a branch shadow was executed",
               $time, dmem_addr_o);
      check_errors++;
    end

  // covers the reset cycles and the first cycle after release
  assert property (@(posedge CLK) (cyc != 0 && $past(RST)) |->
    (!dmem_en_o && !dmem_we_o && imem_addr_o == RESET_FETCH))
    else begin
      $display("CHECK FAILED at %0t: memory strobes or fetch address wrong at reset", $time);
      check_errors++;
    end

  initial begin
    int unsigned waited;
    int          timed_out;
    timed_out = 0;
    pc_idx    = 0;
    next_slot = 0;
    for (int i = 0; i < (1 << `IMEM_AW); i++) begin
      imem[i] = `NOP_INSN;
    end
    for (int i = 0; i < (1 << `DMEM_AW); i++) begin
      dexp[i]      = fill_word(dword_addr_t'(i));
      forbidden[i] = 1'b0;
    end
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    build_program();

    repeat (3) @(posedge CLK);
    RST <= 1'b0;

    waited = 0;
    while (exp_addr.size() != 0 && waited < FINISH_TIMEOUT) begin
      @(negedge CLK);
      waited++;
    end
    if (exp_addr.size() != 0) begin
      $display("timeout: %0d expected stores never happened", exp_addr.size());
      timed_out = 1;
    end

    $display("errors: %0d value checks failed, %0d other failures",
             check_errors, other_errors + timed_out);
    if (check_errors == 0 && other_errors == 0 && timed_out == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* verilog/rv_core.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module rv_core
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic                CLK,
  input  logic                RST,
  output logic [`IMEM_AW-1:0] imem_addr_o,
  input  insn_t               imem_rdata_i,
  output logic                dmem_en_o,
  output logic                dmem_we_o,
  output logic [`DMEM_AW-1:0] dmem_addr_o,
  output word_t               dmem_wdata_o,
  input  word_t               dmem_rdata_i
);

  word_t     pc_q;
  word_t     next_pc;
  insn_t     id_insn;
  word_t     id_pc;
  ctrl_t     id_ctrl;
  word_t     id_imm;
  reg_addr_t id_rs1;
  reg_addr_t id_rs2;
  reg_addr_t id_rd;
  word_t     id_rs1_data;
  word_t     id_rs2_data;
  id_ex_t    id_ex_d;
  id_ex_t    id_ex_q;
  ex_mem_t   ex_mem_d;
  ex_mem_t   ex_mem_q;
  mem_wb_t   mem_wb_d;
  mem_wb_t   mem_wb_q;

  fwd_sel_e  fwd_a;
  fwd_sel_e  fwd_b;
  logic      stall_fetch;
  logic      stall_decode;
  logic      flush_decode;
  logic      flush_execute;

  word_t     ex_rs1_fwd;
  word_t     ex_rs2_fwd;
  word_t     alu_a;
  word_t     alu_b;
  word_t     alu_result;
  logic      branch_cond;
  logic      redirect;
  word_t     jalr_sum;
  word_t     ex_target;
  word_t     mem_fwd_data;
  word_t     wb_result;

  ////////////////////////////////////////
  // fetch
  ////////////////////////////////////////

  assign next_pc     = redirect ? ex_target : pc_q + word_t'(4);
  assign imem_addr_o = pc_q[`IMEM_AW+1:2];

  always_ff @(posedge CLK) begin
    if (RST) begin
      pc_q <= `RESET_PC;
    end else if (!stall_fetch) begin
      pc_q <= next_pc;
    end
  end

  always_ff @(posedge CLK) begin
    if (RST || flush_decode) begin
      id_insn <= `NOP_INSN;
    end else if (!stall_decode) begin
      id_insn <= imem_rdata_i;
      id_pc   <= pc_q;
    end
  end

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////

  insn_decoder u_decoder (
    .insn_i (id_insn),
    .ctrl_o (id_ctrl),
    .imm_o  (id_imm),
    .rs1_o  (id_rs1),
    .rs2_o  (id_rs2),
    .rd_o   (id_rd)
  );

  reg_file u_reg_file (
    .CLK        (CLK),
    .RST        (RST),
    .rs1_i      (id_rs1),
    .rs2_i      (id_rs2),
    .rd_i       (mem_wb_q.rd),
    .we_i       (mem_wb_q.reg_write),
    .wdata_i    (wb_result),
    .rs1_data_o (id_rs1_data),
    .rs2_data_o (id_rs2_data)
  );

  assign id_ex_d = '{
    ctrl:     id_ctrl,
    pc:       id_pc,
    pc_plus4: id_pc + word_t'(4),
    rs1:      id_rs1,
    rs2:      id_rs2,
    rs1_data: id_rs1_data,
    rs2_data: id_rs2_data,
    rd:       id_rd,
    imm:      id_imm
  };

  // a bubble only needs its control cleared
  always_ff @(posedge CLK) begin
    id_ex_q <= id_ex_d;
    if (RST || flush_execute) begin
      id_ex_q.ctrl <= '0;
    end
  end

  ////////////////////////////////////////
  // execute
  ////////////////////////////////////////

  function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_data);
    word_t data;
    case (sel)
      FWD_MEM: data = mem_fwd_data;
      FWD_WB:  data = wb_result;
      default: data = reg_data;
    endcase
    return data;
  endfunction

  always_comb begin
    ex_rs1_fwd = fwd_mux(fwd_a, id_ex_q.rs1_data);
    ex_rs2_fwd = fwd_mux(fwd_b, id_ex_q.rs2_data);
    case (id_ex_q.ctrl.alu_a_sel)
      A_ZERO:  alu_a = '0;
      A_PC:    alu_a = id_ex_q.pc;
      default: alu_a = ex_rs1_fwd;
    endcase
    alu_b = (id_ex_q.ctrl.alu_b_sel == B_IMM) ? id_ex_q.imm : ex_rs2_fwd;
  end

  alu u_alu (
    .a_i           (alu_a),
    .b_i           (alu_b),
    .op_i          (id_ex_q.ctrl.alu_op),
    .result_o      (alu_result),
    .branch_cond_o (branch_cond)
  );

  // jalr target drops bit 0
  assign jalr_sum  = ex_rs1_fwd + id_ex_q.imm;
  assign ex_target = id_ex_q.ctrl.jalr ? {jalr_sum[`XLEN-1:1], 1'b0}
                                       : id_ex_q.pc + id_ex_q.imm;
  assign redirect  = id_ex_q.ctrl.jump || (id_ex_q.ctrl.branch && branch_cond);

  assign ex_mem_d = '{
    ctrl:       id_ex_q.ctrl,
    alu_result: alu_result,
    store_data: ex_rs2_fwd,
    rd:         id_ex_q.rd,
    pc_plus4:   id_ex_q.pc_plus4
  };

  always_ff @(posedge CLK) begin
    ex_mem_q <= ex_mem_d;
    if (RST) begin
      ex_mem_q.ctrl <= '0;
    end
  end

  ////////////////////////////////////////
  // memory
  ////////////////////////////////////////

  assign dmem_en_o    = ex_mem_q.ctrl.mem_read || ex_mem_q.ctrl.mem_write;
  assign dmem_we_o    = ex_mem_q.ctrl.mem_write;
  assign dmem_addr_o  = ex_mem_q.alu_result[`DMEM_AW+1:2];
  assign dmem_wdata_o = ex_mem_q.store_data;

  // link value of a jump sitting in memory
  assign mem_fwd_data = (ex_mem_q.ctrl.result_sel == RES_PC4) ? ex_mem_q.pc_plus4
                                                              : ex_mem_q.alu_result;

  assign mem_wb_d = '{
    reg_write:  ex_mem_q.ctrl.reg_write,
    result_sel: ex_mem_q.ctrl.result_sel,
    alu_result: ex_mem_q.alu_result,
    rd:         ex_mem_q.rd,
    pc_plus4:   ex_mem_q.pc_plus4
  };

  always_ff @(posedge CLK) begin
    mem_wb_q <= mem_wb_d;
    if (RST) begin
      mem_wb_q.reg_write <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // writeback
  ////////////////////////////////////////

  // load data arrives from the memory one cycle after the strobe
  always_comb begin
    case (mem_wb_q.result_sel)
      RES_MEM: wb_result = dmem_rdata_i;
      RES_PC4: wb_result = mem_wb_q.pc_plus4;
      default: wb_result = mem_wb_q.alu_result;
    endcase
  end

  hazard_unit u_hazard (
    .id_rs1_i        (id_rs1),
    .id_rs2_i        (id_rs2),
    .ex_rs1_i        (id_ex_q.rs1),
    .ex_rs2_i        (id_ex_q.rs2),
    .ex_rd_i         (id_ex_q.rd),
    .mem_rd_i        (ex_mem_q.rd),
    .wb_rd_i         (mem_wb_q.rd),
    .ex_mem_read_i   (id_ex_q.ctrl.mem_read),
    .mem_reg_write_i (ex_mem_q.ctrl.reg_write),
    .mem_mem_read_i  (ex_mem_q.ctrl.mem_read),
    .wb_reg_write_i  (mem_wb_q.reg_write),
    .redirect_i      (redirect),
    .fwd_a_o         (fwd_a),
    .fwd_b_o         (fwd_b),
    .stall_fetch_o   (stall_fetch),
    .stall_decode_o  (stall_decode),
    .flush_decode_o  (flush_decode),
    .flush_execute_o (flush_execute)
  );

  assert property (@(posedge CLK) disable iff (RST) dmem_we_o |-> dmem_en_o)
    else $error("data write strobe without enable");

  assert property (@(posedge CLK) disable iff (RST)
    dmem_en_o |-> (ex_mem_q.alu_result[1:0] == 2'b00))
    else $error("data access to a misaligned byte address");

endmodule

/* verilog/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit
  import isa_pkg::*;
(
  input  reg_addr_t id_rs1_i,
  input  reg_addr_t id_rs2_i,
  input  reg_addr_t ex_rs1_i,
  input  reg_addr_t ex_rs2_i,
  input  reg_addr_t ex_rd_i,
  input  reg_addr_t mem_rd_i,
  input  reg_addr_t wb_rd_i,
  input  logic      ex_mem_read_i,
  input  logic      mem_reg_write_i,
  input  logic      mem_mem_read_i,
  input  logic      wb_reg_write_i,
  input  logic      redirect_i,
  output fwd_sel_e  fwd_a_o,
  output fwd_sel_e  fwd_b_o,
  output logic      stall_fetch_o,
  output logic      stall_decode_o,
  output logic      flush_decode_o,
  output logic      flush_execute_o
);

  logic ex_load_hit;
  logic mem_load_hit;
  logic load_use;

  // memory stage first, it holds the younger value
  function automatic fwd_sel_e fwd_for(reg_addr_t rs);
    fwd_sel_e sel;
    if (rs == '0) begin
      sel = FWD_NONE;
    end else if (mem_reg_write_i && !mem_mem_read_i && rs == mem_rd_i) begin
      sel = FWD_MEM;
    end else if (wb_reg_write_i && rs == wb_rd_i) begin
      sel = FWD_WB;
    end else begin
      sel = FWD_NONE;
    end
    return sel;
  endfunction

  always_comb begin
    fwd_a_o = fwd_for(ex_rs1_i);
    fwd_b_o = fwd_for(ex_rs2_i);
  end

  // load data only exists in writeback, so hold decode until then
  assign ex_load_hit  = ex_mem_read_i && ex_rd_i != '0 &&
                        (ex_rd_i == id_rs1_i || ex_rd_i == id_rs2_i);
  assign mem_load_hit = mem_mem_read_i && mem_rd_i != '0 &&
                        (mem_rd_i == id_rs1_i || mem_rd_i == id_rs2_i);
  assign load_use     = ex_load_hit || mem_load_hit;

  // a redirect kills the waiting instruction anyway
  assign stall_fetch_o   = load_use && !redirect_i;
  assign stall_decode_o  = load_use && !redirect_i;
  assign flush_decode_o  = redirect_i;
  assign flush_execute_o = redirect_i || load_use;

  // a load in execute can never redirect, so its stall never meets a decode flush
  always_comb begin
    assert final (!(ex_load_hit && redirect_i))
      else $error("load-use stall of decode raised together with a decode flush");
  end

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ps

module alu
  import isa_pkg::*;
(
  input  word_t   a_i,
  input  word_t   b_i,
  input  alu_op_e op_i,
  output word_t   result_o,
  output logic    branch_cond_o
);

  logic eq;
  logic lt_s;
  logic lt_u;

  // one set of comparators serves SLT and the branches
  assign eq   = (a_i == b_i);
  assign lt_s = $signed(a_i) < $signed(b_i);
  assign lt_u = a_i < b_i;

  always_comb begin
    case (op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_AND:  result_o = a_i & b_i;
      ALU_OR:   result_o = a_i | b_i;
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_SLT:  result_o = word_t'(lt_s);
      ALU_SLTU: result_o = word_t'(lt_u);
      ALU_SLL:  result_o = a_i << b_i[4:0];
      ALU_SRL:  result_o = a_i >> b_i[4:0];
      ALU_SRA:  result_o = word_t'($signed(a_i) >>> b_i[4:0]);
      ALU_EQ:   result_o = word_t'(eq);
      ALU_NE:   result_o = word_t'(!eq);
      ALU_GE:   result_o = word_t'(!lt_s);
      default:  result_o = '0;
    endcase
  end

  always_comb begin
    case (op_i)
      ALU_EQ:  branch_cond_o = eq;
      ALU_NE:  branch_cond_o = !eq;
      ALU_SLT: branch_cond_o = lt_s;
      ALU_GE:  branch_cond_o = !lt_s;
      default: branch_cond_o = 1'b0;
    endcase
  end

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/1ps

module reg_file
  import isa_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  reg_addr_t rs1_i,
  input  reg_addr_t rs2_i,
  input  reg_addr_t rd_i,
  input  logic      we_i,
  input  word_t     wdata_i,
  output word_t     rs1_data_o,
  output word_t     rs2_data_o
);

  // x0 has no storage
  word_t regs [1:31];

  function automatic word_t read_port(reg_addr_t addr);
    word_t data;
    if (addr == '0) begin
      data = '0;
    end else if (we_i && addr == rd_i) begin
      // writeback in the same cycle wins over the stored value
      data = wdata_i;
    end else begin
      data = regs[addr];
    end
    return data;
  endfunction

  always_ff @(posedge CLK) begin
    if (we_i && rd_i != '0) begin
      regs[rd_i] <= wdata_i;
    end
  end

  always_comb begin
    rs1_data_o = read_port(rs1_i);
    rs2_data_o = read_port(rs2_i);
  end

  assert property (@(posedge CLK) disable iff (RST)
    !((rs1_i == '0 && rs1_data_o != '0) || (rs2_i == '0 && rs2_data_o != '0)))
    else $error("x0 read returned nonzero data");

endmodule

/* verilog/insn_decoder.sv */
`timescale 1ns/1ps

module insn_decoder
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  insn_t     insn_i,
  output ctrl_t     ctrl_o,
  output word_t     imm_o,
  output reg_addr_t rs1_o,
  output reg_addr_t rs2_o,
  output reg_addr_t rd_o
);

  insn_fields_t f;
  imm_type_e    imm_type;
  alu_op_e      arith_op;
  logic         use_rs1;
  logic         use_rs2;

  assign f = insn_fields_t'(insn_i);

  // alu decode for OP and OP-IMM
  always_comb begin
    case (f.funct3)
      F3_ADD:  arith_op = (f.opcode == OPC_OP && f.funct7[5]) ? ALU_SUB : ALU_ADD;
      F3_SLL:  arith_op = ALU_SLL;
      F3_SLT:  arith_op = ALU_SLT;
      F3_SLTU: arith_op = ALU_SLTU;
      F3_XOR:  arith_op = ALU_XOR;
      // bit 30 picks arithmetic shift in both forms
      F3_SR:   arith_op = f.funct7[5] ? ALU_SRA : ALU_SRL;
      F3_OR:   arith_op = ALU_OR;
      F3_AND:  arith_op = ALU_AND;
      default: arith_op = ALU_ADD;
    endcase
  end

  // main decode
  always_comb begin
    ctrl_o   = '0;
    imm_type = IMM_I;
    use_rs1  = 1'b0;
    use_rs2  = 1'b0;
    case (f.opcode)
      OPC_OP: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.alu_op    = arith_op;
        use_rs1          = 1'b1;
        use_rs2          = 1'b1;
      end
      OPC_OP_IMM: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.alu_op    = arith_op;
        ctrl_o.alu_b_sel = B_IMM;
        use_rs1          = 1'b1;
      end
      OPC_LUI, OPC_AUIPC: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.alu_a_sel = (f.opcode == OPC_LUI) ? A_ZERO : A_PC;
        ctrl_o.alu_b_sel = B_IMM;
        imm_type         = IMM_U;
      end
      OPC_JAL: begin
        ctrl_o.reg_write  = 1'b1;
        ctrl_o.jump       = 1'b1;
        ctrl_o.result_sel = RES_PC4;
        imm_type          = IMM_J;
      end
      OPC_JALR: begin
        ctrl_o.reg_write  = 1'b1;
        ctrl_o.jump       = 1'b1;
        ctrl_o.jalr       = 1'b1;
        ctrl_o.result_sel = RES_PC4;
        use_rs1           = 1'b1;
      end
      OPC_BRANCH: begin
        imm_type = IMM_B;
        use_rs1  = 1'b1;
        use_rs2  = 1'b1;
        ctrl_o.branch = 1'b1;
        case (f.funct3)
          F3_BEQ:  ctrl_o.alu_op = ALU_EQ;
          F3_BNE:  ctrl_o.alu_op = ALU_NE;
          F3_BLT:  ctrl_o.alu_op = ALU_SLT;
          F3_BGE:  ctrl_o.alu_op = ALU_GE;
          // unsigned branches are not kept
          default: ctrl_o.branch = 1'b0;
        endcase
      end
      OPC_LOAD: begin
        ctrl_o.reg_write  = 1'b1;
        ctrl_o.mem_read   = 1'b1;
        ctrl_o.alu_b_sel  = B_IMM;
        ctrl_o.result_sel = RES_MEM;
        use_rs1           = 1'b1;
      end
      OPC_STORE: begin
        ctrl_o.mem_write = 1'b1;
        ctrl_o.alu_b_sel = B_IMM;
        imm_type         = IMM_S;
        use_rs1          = 1'b1;
        use_rs2          = 1'b1;
      end
      default: ;
    endcase
  end

  // immediate extension
  always_comb begin
    case (imm_type)
      IMM_S:   imm_o = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
      IMM_B:   imm_o = {{19{insn_i[31]}}, insn_i[31], insn_i[7], insn_i[30:25],
                        insn_i[11:8], 1'b0};
      IMM_U:   imm_o = {insn_i[31:12], 12'b0};
      IMM_J:   imm_o = {{11{insn_i[31]}}, insn_i[31], insn_i[19:12], insn_i[20],
                        insn_i[30:21], 1'b0};
      default: imm_o = {{20{insn_i[31]}}, insn_i[31:20]};
    endcase
  end

  // unused fields read as x0 so they never match a producer
  assign rs1_o = use_rs1 ? f.rs1 : '0;
  assign rs2_o = use_rs2 ? f.rs2 : '0;
  assign rd_o  = ctrl_o.reg_write ? f.rd : '0;

endmodule

/* verilog/pipe_pkg.sv */
package pipe_pkg;

  import isa_pkg::*;

  // an all-zero control word behaves as a no-operation
  typedef struct packed {
    logic        reg_write;
    logic        mem_read;
    logic        mem_write;
    logic        branch;
    logic        jump;
    logic        jalr;
    alu_op_e     alu_op;
    alu_a_sel_e  alu_a_sel;
    alu_b_sel_e  alu_b_sel;
    result_sel_e result_sel;
  } ctrl_t;

  // decode to execute
  typedef struct packed {
    ctrl_t     ctrl;
    word_t     pc;
    word_t     pc_plus4;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    reg_addr_t rd;
    word_t     imm;
  } id_ex_t;

  // execute to memory
  typedef struct packed {
    ctrl_t     ctrl;
    word_t     alu_result;
    word_t     store_data;
    reg_addr_t rd;
    word_t     pc_plus4;
  } ex_mem_t;

  // memory to writeback, only what the result mux and register file need
  typedef struct packed {
    logic        reg_write;
    result_sel_e result_sel;
    word_t       alu_result;
    reg_addr_t   rd;
    word_t       pc_plus4;
  } mem_wb_t;

endpackage

/* verilog/isa_pkg.sv */
`include "core_settings.svh"

package isa_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [4:0]       reg_addr_t;
  typedef logic [31:0]      insn_t;
  typedef logic [2:0]       funct3_t;
  typedef logic [6:0]       funct7_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  // funct3 of register and immediate ALU ops
  typedef enum logic [2:0] {
    F3_ADD  = 3'b000,
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SR   = 3'b101,
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } alu_f3_e;

  // funct3 of the kept branches
  typedef enum logic [2:0] {
    F3_BEQ = 3'b000,
    F3_BNE = 3'b001,
    F3_BLT = 3'b100,
    F3_BGE = 3'b101
  } br_f3_e;

  // R-type field split, the other formats reuse the same positions
  typedef struct packed {
    funct7_t   funct7;
    reg_addr_t rs2;
    reg_addr_t rs1;
    funct3_t   funct3;
    reg_addr_t rd;
    opcode_e   opcode;
  } insn_fields_t;

  ////////////////////////////////////////
  // datapath selects
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_EQ, ALU_NE, ALU_GE
  } alu_op_e;

  typedef enum logic [1:0] {A_REG, A_ZERO, A_PC} alu_a_sel_e;
  typedef enum logic {B_REG, B_IMM} alu_b_sel_e;
  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_type_e;
  typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4} result_sel_e;
  typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_e;

endpackage

/* verilog/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// width of register data, ALU operands and the PC
`define XLEN 32

// first fetch address once reset is released
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0 placed in flushed or reset stages
`define NOP_INSN 32'h0000_0013

// word address widths of the two memory ports
`define IMEM_AW 10
`define DMEM_AW 10

`endif
